// File: include/rv_defines.svh
/*
 * Core-wide size macros for the single-cycle RV32I core: data width,
 * reset vector, register count and register index width.
 */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width of the core
`define RV_XLEN 32

// first fetch address once reset is released
`define RV_RESET_VECTOR 32'h0000_0000

// architectural integer registers, x0 included
`define RV_NUM_REGS 32

// width of a register index field in the instruction word
`define RV_REG_ADDR_W 5

`endif

// File: verilog/rv_isa_pkg.sv
/*
 * Instruction-set types: base opcodes, ALU and branch funct3 encodings,
 * the machine word and the register index.
 */
`include "rv_defines.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_idx_t;

  // major opcodes of RV32I, only the ones this core knows by name
  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'b0000011,
    OPCODE_MISC_MEM = 7'b0001111,
    OPCODE_OP_IMM   = 7'b0010011,
    OPCODE_AUIPC    = 7'b0010111,
    OPCODE_STORE    = 7'b0100011,
    OPCODE_OP       = 7'b0110011,
    OPCODE_LUI      = 7'b0110111,
    OPCODE_BRANCH   = 7'b1100011,
    OPCODE_JALR     = 7'b1100111,
    OPCODE_JAL      = 7'b1101111
  } opcode_e;

  // funct3 of OP and OP-IMM, bit 5 of funct7 splits ADD/SUB and SRL/SRA
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_alu_e;

  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } funct3_branch_e;

endpackage

// File: verilog/rv_ctrl_pkg.sv
/*
 * Control types: next-PC, operand and writeback selects, ALU operation
 * class, the decoded control bundle and the data memory request.
 */
package rv_ctrl_pkg;

  import rv_isa_pkg::*;

  typedef enum logic [1:0] {
    CTL_PC_PC4     = 2'b00,
    CTL_PC_PC_IMM  = 2'b01,
    CTL_PC_RS1_IMM = 2'b10
  } next_pc_sel_e;

  typedef enum logic {
    CTL_ALU_A_RS1 = 1'b0,
    CTL_ALU_A_PC  = 1'b1
  } alu_a_sel_e;

  typedef enum logic {
    CTL_ALU_B_RS2 = 1'b0,
    CTL_ALU_B_IMM = 1'b1
  } alu_b_sel_e;

  // the ALU refines OP, OP_IMM and BRANCH further from funct3 and funct7
  typedef enum logic [1:0] {
    CTL_ALU_ADD    = 2'b00,
    CTL_ALU_OP     = 2'b01,
    CTL_ALU_OP_IMM = 2'b10,
    CTL_ALU_BRANCH = 2'b11
  } alu_class_e;

  typedef enum logic [2:0] {
    CTL_WRITEBACK_ALU  = 3'b000,
    CTL_WRITEBACK_IMM  = 3'b001,
    CTL_WRITEBACK_PC4  = 3'b010,
    CTL_WRITEBACK_DATA = 3'b011
  } wb_sel_e;

  typedef struct packed {
    logic       regfile_write_enable;
    alu_a_sel_e alu_a_select;
    alu_b_sel_e alu_b_select;
    alu_class_e alu_class;
    logic       mem_read_enable;
    logic       mem_write_enable;
    wb_sel_e    writeback_select;
  } ctrl_t;

  // write_strobe lasts one cycle, memory takes wdata on the closing edge
  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write_strobe;
    logic  read_enable;
  } dmem_req_t;

endpackage

// File: verilog/alu.sv
/*
 * Integer ALU: refines the operation class with funct3 and funct7 bit 5,
 * computes the result and evaluates the branch condition.
 */
`timescale 1ns/10ps

module alu import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  alu_class_e  alu_class,
  input  logic [2:0]  funct3,
  input  logic        funct7_bit5,
  input  word_t       operand_a,
  input  word_t       operand_b,
  output word_t       result,
  output logic        take_branch
);

  localparam int SHAMT_W = $clog2($bits(word_t));

  funct3_alu_e        alu_fn;
  funct3_branch_e     branch_fn;
  logic [SHAMT_W-1:0] shamt;
  logic               is_sub;

  assign alu_fn    = funct3_alu_e'(funct3);
  assign branch_fn = funct3_branch_e'(funct3);
  assign shamt     = operand_b[SHAMT_W-1:0];
  // immediates reuse bit 30 as data, so only register OP may subtract
  assign is_sub    = (alu_class == CTL_ALU_OP) && funct7_bit5;

  always_comb begin
    result      = operand_a + operand_b;
    take_branch = 1'b0;
    case (alu_class)
      CTL_ALU_OP, CTL_ALU_OP_IMM: begin
        case (alu_fn)
          F3_ADD_SUB: result = is_sub ? operand_a - operand_b : operand_a + operand_b;
          F3_SLL:     result = operand_a << shamt;
          F3_SLT:     result = word_t'($signed(operand_a) < $signed(operand_b));
          F3_SLTU:    result = word_t'(operand_a < operand_b);
          F3_XOR:     result = operand_a ^ operand_b;
          F3_SRL_SRA: begin
            if (funct7_bit5) begin
              result = word_t'($signed(operand_a) >>> shamt);
            end else begin
              result = operand_a >> shamt;
            end
          end
          F3_OR:      result = operand_a | operand_b;
          F3_AND:     result = operand_a & operand_b;
          default:    result = operand_a + operand_b;
        endcase
      end
      CTL_ALU_BRANCH: begin
        result = operand_a - operand_b;
        case (branch_fn)
          F3_BEQ:  take_branch = operand_a == operand_b;
          F3_BNE:  take_branch = operand_a != operand_b;
          F3_BLT:  take_branch = $signed(operand_a) < $signed(operand_b);
          F3_BGE:  take_branch = $signed(operand_a) >= $signed(operand_b);
          F3_BLTU: take_branch = operand_a < operand_b;
          F3_BGEU: take_branch = operand_a >= operand_b;
          default: take_branch = 1'b0;
        endcase
      end
      default: begin
      end
    endcase
  end

endmodule

// File: verilog/immediate_generator.sv
/*
 * Immediate generator: sign-extended I, S, B, U and J immediates,
 * with the format picked from the opcode.
 */
`timescale 1ns/10ps

module immediate_generator import rv_isa_pkg::*; (
  input  word_t inst,
  output word_t imm
);

  opcode_e opcode;

  assign opcode = opcode_e'(inst[6:0]);

  always_comb begin
    case (opcode)
      OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_JALR: begin
        imm = {{20{inst[31]}}, inst[31:20]};
      end
      OPCODE_STORE: begin
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      // branch and jump offsets are in halfwords, so bit 0 is always zero
      OPCODE_BRANCH: begin
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      OPCODE_JAL: begin
        imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        imm = {inst[31:12], 12'b0};
      end
      // OP has no immediate, neither do FENCE or unknown opcodes
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// File: verilog/regfile.sv
/*
 * Integer register file: two combinational read ports,
 * one write port on the clock edge, x0 hard-wired to zero.
 */
`timescale 1ns/10ps
`include "rv_defines.svh"

module regfile import rv_isa_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     write_enable,
  input  reg_idx_t rd,
  input  word_t    rd_data,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [`RV_NUM_REGS];

  // entry 0 is cleared by reset and never written afterwards
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  x0_stays_zero: assert property (@(posedge clock) disable iff (reset)
    (write_enable && rd == '0) |=> (regs[0] == '0));

endmodule

// File: verilog/singlecycle_control.sv
/*
 * Single-cycle control decoder: opcode and branch outcome in,
 * control bundle and next-PC choice out.
 */
`timescale 1ns/10ps

module singlecycle_control import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  opcode_e      opcode,
  input  logic         take_branch,
  output ctrl_t        ctrl,
  output next_pc_sel_e next_pc_select
);

  ctrl_t decoded;

  always_comb begin
    case (opcode)
      OPCODE_BRANCH: next_pc_select = take_branch ? CTL_PC_PC_IMM : CTL_PC_PC4;
      OPCODE_JALR:   next_pc_select = CTL_PC_RS1_IMM;
      OPCODE_JAL:    next_pc_select = CTL_PC_PC_IMM;
      default:       next_pc_select = CTL_PC_PC4;
    endcase
  end

  // defaults describe a no-op, so MISC_MEM and unknown opcodes keep them
  always_comb begin
    decoded.regfile_write_enable = 1'b0;
    decoded.alu_a_select         = CTL_ALU_A_RS1;
    decoded.alu_b_select         = CTL_ALU_B_RS2;
    decoded.alu_class            = CTL_ALU_ADD;
    decoded.mem_read_enable      = 1'b0;
    decoded.mem_write_enable     = 1'b0;
    decoded.writeback_select     = CTL_WRITEBACK_ALU;
    case (opcode)
      OPCODE_LUI: begin
        decoded.regfile_write_enable = 1'b1;
        decoded.writeback_select     = CTL_WRITEBACK_IMM;
      end
      OPCODE_AUIPC: begin
        decoded.regfile_write_enable = 1'b1;
        decoded.alu_a_select         = CTL_ALU_A_PC;
        decoded.alu_b_select         = CTL_ALU_B_IMM;
      end
      OPCODE_JAL: begin
        decoded.regfile_write_enable = 1'b1;
        decoded.alu_a_select         = CTL_ALU_A_PC;
        decoded.alu_b_select         = CTL_ALU_B_IMM;
        decoded.writeback_select     = CTL_WRITEBACK_PC4;
      end
      OPCODE_JALR: begin
        // the ALU forms rs1 + imm, the datapath clears bit 0
        decoded.regfile_write_enable = 1'b1;
        decoded.alu_b_select         = CTL_ALU_B_IMM;
        decoded.writeback_select     = CTL_WRITEBACK_PC4;
      end
      OPCODE_BRANCH: begin
        decoded.alu_class = CTL_ALU_BRANCH;
      end
      OPCODE_LOAD: begin
        decoded.regfile_write_enable = 1'b1;
        decoded.alu_b_select         = CTL_ALU_B_IMM;
        decoded.mem_read_enable      = 1'b1;
        decoded.writeback_select     = CTL_WRITEBACK_DATA;
      end
      OPCODE_STORE: begin
        decoded.alu_b_select     = CTL_ALU_B_IMM;
        decoded.mem_write_enable = 1'b1;
      end
      OPCODE_OP_IMM: begin
        decoded.regfile_write_enable = 1'b1;
        decoded.alu_b_select         = CTL_ALU_B_IMM;
        decoded.alu_class            = CTL_ALU_OP_IMM;
      end
      OPCODE_OP: begin
        decoded.regfile_write_enable = 1'b1;
        decoded.alu_class            = CTL_ALU_OP;
      end
      default: begin
      end
    endcase
  end

  // no architectural write may happen while the core is held in reset
  always_comb begin
    ctrl                      = decoded;
    ctrl.regfile_write_enable = decoded.regfile_write_enable & ~reset;
    ctrl.mem_write_enable     = decoded.mem_write_enable & ~reset;
  end

  read_write_exclusive: assert property (@(posedge clock)
    !(ctrl.mem_read_enable && ctrl.mem_write_enable));

  no_store_in_reset: assert property (@(posedge clock)
    reset |-> !ctrl.mem_write_enable);

endmodule

// File: verilog/singlecycle_datapath.sv
/*
 * Single-cycle datapath: PC register, instruction field split, operand and
 * writeback multiplexers, next-PC logic, ALU, immediates and register file.
 */
`timescale 1ns/10ps
`include "rv_defines.svh"

module singlecycle_datapath import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  ctrl_t        ctrl,
  input  next_pc_sel_e next_pc_select,
  output opcode_e      opcode,
  output logic         take_branch,
  output word_t        imem_addr,
  input  word_t        imem_data,
  output dmem_req_t    dmem_req,
  input  word_t        dmem_rdata
);

  word_t    pc;
  word_t    next_pc;
  word_t    pc_plus_4;
  word_t    pc_plus_imm;
  word_t    jalr_target;
  word_t    imm;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_result;
  word_t    rd_data;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic [2:0] funct3;
  logic     funct7_bit5;

  assign opcode      = opcode_e'(imem_data[6:0]);
  assign rd          = imem_data[11:7];
  assign funct3      = imem_data[14:12];
  assign rs1         = imem_data[19:15];
  assign rs2         = imem_data[24:20];
  assign funct7_bit5 = imem_data[30];

  assign imem_addr = pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= `RV_RESET_VECTOR;
    end else begin
      pc <= next_pc;
    end
  end

  assign pc_plus_4   = pc + word_t'(4);
  assign pc_plus_imm = pc + imm;
  // JALR target comes from the ALU sum rs1 + imm with the low bit dropped
  assign jalr_target = alu_result & ~word_t'(1);

  always_comb begin
    case (next_pc_select)
      CTL_PC_PC_IMM:  next_pc = pc_plus_imm;
      CTL_PC_RS1_IMM: next_pc = jalr_target;
      default:        next_pc = pc_plus_4;
    endcase
  end

  assign alu_a = (ctrl.alu_a_select == CTL_ALU_A_PC) ? pc : rs1_data;
  assign alu_b = (ctrl.alu_b_select == CTL_ALU_B_IMM) ? imm : rs2_data;

  always_comb begin
    case (ctrl.writeback_select)
      CTL_WRITEBACK_IMM:  rd_data = imm;
      CTL_WRITEBACK_PC4:  rd_data = pc_plus_4;
      CTL_WRITEBACK_DATA: rd_data = dmem_rdata;
      default:            rd_data = alu_result;
    endcase
  end

  assign dmem_req.addr         = alu_result;
  assign dmem_req.wdata        = rs2_data;
  assign dmem_req.write_strobe = ctrl.mem_write_enable;
  assign dmem_req.read_enable  = ctrl.mem_read_enable;

  alu alu_inst (
    .alu_class   (ctrl.alu_class),
    .funct3      (funct3),
    .funct7_bit5 (funct7_bit5),
    .operand_a   (alu_a),
    .operand_b   (alu_b),
    .result      (alu_result),
    .take_branch (take_branch)
  );

  immediate_generator immediate_generator_inst (
    .inst (imem_data),
    .imm  (imm)
  );

  regfile regfile_inst (
    .clock        (clock),
    .reset        (reset),
    .write_enable (ctrl.regfile_write_enable),
    .rd           (rd),
    .rd_data      (rd_data),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

endmodule

// File: verilog/rv_core.sv
/*
 * Top level of the single-cycle RV32I core: control decoder and
 * datapath joined to the instruction and data memory ports.
 */
`timescale 1ns/10ps

module rv_core import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  output word_t     imem_addr,
  input  word_t     imem_data,
  output dmem_req_t dmem_req,
  input  word_t     dmem_rdata
);

  opcode_e      opcode;
  logic         take_branch;
  ctrl_t        ctrl;
  next_pc_sel_e next_pc_select;

  singlecycle_control control_inst (
    .clock          (clock),
    .reset          (reset),
    .opcode         (opcode),
    .take_branch    (take_branch),
    .ctrl           (ctrl),
    .next_pc_select (next_pc_select)
  );

  // one instruction retires on every rising edge
  singlecycle_datapath datapath_inst (
    .clock          (clock),
    .reset          (reset),
    .ctrl           (ctrl),
    .next_pc_select (next_pc_select),
    .opcode         (opcode),
    .take_branch    (take_branch),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .dmem_req       (dmem_req),
    .dmem_rdata     (dmem_rdata)
  );

endmodule

// File: verification/rv_core_tb.sv
/*
 * Testbench for rv_core: clock and reset, instruction encoders, program
 * builders, memory models, instruction-set reference model, compare tasks, watchdog.
 */
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_core_tb import rv_isa_pkg::*, rv_ctrl_pkg::*; ();

  localparam int PERIOD_NS      = 100;
  localparam int RESET_CYCLES   = 5;
  localparam int MEM_WORDS      = 256;
  localparam int MAX_PROG       = 64;
  localparam int NUM_TESTS      = 4;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (MAX_PROG + RESET_CYCLES + 4) + 50;

  logic      clock;
  logic      reset;
  word_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;

  word_t  imem [MEM_WORDS];
  word_t  dmem [MEM_WORDS];
  word_t  ref_mem [MEM_WORDS];
  word_t  ref_regs [`RV_NUM_REGS];
  word_t  ref_pc;
  integer seed = 32'ha4f2312e;
  string  test_name;
  int     prog_len;
  logic   checking;
  logic   halted;

  rv_core rv_core_inst (
    .clock      (clock),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // both memories answer within the cycle, the data memory writes on the edge
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_req.addr[9:2]];

  always @(posedge clock) begin
    if (dmem_req.write_strobe) begin
      dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  function automatic word_t fill_word(input int index);
    return word_t'(index) * 32'h9e37_79b9 + 32'h0135_7acf;
  endfunction

  function automatic string describe_req(input dmem_req_t req);
    return $sformatf("addr=%h data=%h strobe=%b read=%b", req.addr, req.wdata,
                     req.write_strobe, req.read_enable);
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                   input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
  endfunction

  // architectural effect of one instruction, straight from the RV32I rules
  function automatic void iss_step(input word_t pc, input word_t inst, output word_t next_pc,
                                   output logic rd_we, output reg_idx_t rd,
                                   output word_t rd_val, output dmem_req_t store);
    word_t rs1_val;
    word_t rs2_val;
    word_t src2;
    word_t addr;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    logic  taken;
    rs1_val = ref_regs[inst[19:15]];
    rs2_val = ref_regs[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u   = {inst[31:12], 12'h000};
    imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    next_pc = pc + 32'd4;
    rd      = inst[11:7];
    rd_we   = 1'b0;
    rd_val  = '0;
    store   = '0;
    taken   = 1'b0;
    case (inst[6:0])
      OPCODE_LUI: begin
        rd_we  = 1'b1;
        rd_val = imm_u;
      end
      OPCODE_AUIPC: begin
        rd_we  = 1'b1;
        rd_val = pc + imm_u;
      end
      OPCODE_JAL: begin
        rd_we   = 1'b1;
        rd_val  = pc + 32'd4;
        next_pc = pc + imm_j;
      end
      OPCODE_JALR: begin
        rd_we   = 1'b1;
        rd_val  = pc + 32'd4;
        next_pc = (rs1_val + imm_i) & 32'hffff_fffe;
      end
      OPCODE_BRANCH: begin
        case (inst[14:12])
          3'd0:    taken = rs1_val == rs2_val;
          3'd1:    taken = rs1_val != rs2_val;
          3'd4:    taken = $signed(rs1_val) < $signed(rs2_val);
          3'd5:    taken = $signed(rs1_val) >= $signed(rs2_val);
          3'd6:    taken = rs1_val < rs2_val;
          3'd7:    taken = rs1_val >= rs2_val;
          default: taken = 1'b0;
        endcase
        if (taken) begin
          next_pc = pc + imm_b;
        end
      end
      OPCODE_LOAD: begin
        addr              = rs1_val + imm_i;
        rd_we             = 1'b1;
        rd_val            = ref_mem[addr[9:2]];
        store.addr        = addr;
        store.read_enable = 1'b1;
      end
      OPCODE_STORE: begin
        store.addr         = rs1_val + imm_s;
        store.wdata        = rs2_val;
        store.write_strobe = 1'b1;
      end
      OPCODE_OP_IMM, OPCODE_OP: begin
        src2  = (inst[6:0] == OPCODE_OP) ? rs2_val : imm_i;
        rd_we = 1'b1;
        case (inst[14:12])
          3'd0: rd_val = (inst[6:0] == OPCODE_OP && inst[30]) ? rs1_val - src2 : rs1_val + src2;
          3'd1: rd_val = rs1_val << src2[4:0];
          3'd2: rd_val = {31'b0, $signed(rs1_val) < $signed(src2)};
          3'd3: rd_val = {31'b0, rs1_val < src2};
          3'd4: rd_val = rs1_val ^ src2;
          3'd5: rd_val = inst[30] ? word_t'($signed(rs1_val) >>> src2[4:0]) : rs1_val >> src2[4:0];
          3'd6: rd_val = rs1_val | src2;
          default: rd_val = rs1_val & src2;
        endcase
      end
      // FENCE and every unknown opcode only move the PC on
      default: begin
      end
    endcase
  endfunction

  task automatic check_pc(input word_t expected, input word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s: fetch address expected %h actual %h",
                          test_name, expected, actual));
    end
  endtask

  task automatic check_dmem(input dmem_req_t expected, input dmem_req_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s: data request expected %s actual %s",
                          test_name, describe_req(expected), describe_req(actual)));
    end
  endtask

  task automatic compare_step();
    word_t     next_pc;
    word_t     rd_val;
    reg_idx_t  rd;
    logic      rd_we;
    dmem_req_t store;
    dmem_req_t seen;
    check_pc(ref_pc, imem_addr);
    iss_step(ref_pc, imem[ref_pc[9:2]], next_pc, rd_we, rd, rd_val, store);
    if (store.write_strobe || dmem_req.write_strobe) begin
      check_dmem(store, dmem_req);
    end else if (store.read_enable || dmem_req.read_enable) begin
      // write data has no meaning on a load
      seen       = dmem_req;
      seen.wdata = '0;
      check_dmem(store, seen);
    end
    if (store.write_strobe) begin
      ref_mem[store.addr[9:2]] = store.wdata;
    end
    if (rd_we && rd != 5'd0) begin
      ref_regs[rd] = rd_val;
    end
    // a jump onto itself closes every program
    halted = (next_pc == ref_pc);
    ref_pc = next_pc;
  endtask

  // outputs settle well before the falling edge
  always @(negedge clock) begin
    if (reset) begin
      if (dmem_req.write_strobe) begin
        abort_run("the core requested a data memory write while reset was high");
      end
    end else if (checking) begin
      compare_step();
    end
  end

  task automatic emit(input word_t inst);
    imem[prog_len] = inst;
    prog_len++;
  endtask

  task automatic reset_models();
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i]    = '0;
      dmem[i]    <= fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    ref_pc   = `RV_RESET_VECTOR;
    prog_len = 0;
  endtask

  task automatic start_test(input string name);
    @(posedge clock);
    reset    <= 1'b1;
    checking <= 1'b0;
    @(posedge clock);
    test_name = name;
    halted    = 1'b0;
    reset_models();
  endtask

  task automatic run_to_halt();
    emit(j_type(21'd0, 5'd0));
    repeat (RESET_CYCLES - 1) @(posedge clock);
    reset    <= 1'b0;
    checking <= 1'b1;
    wait (halted);
    repeat (2) @(posedge clock);
    checking <= 1'b0;
    $display("test %s reached its halt loop at %h", test_name, ref_pc);
  endtask

  task automatic alu_program();
    word_t       r;
    reg_idx_t    rd;
    logic [2:0]  f3;
    logic [11:0] imm12;
    // a store sits at the reset vector and is fetched all through reset
    emit(s_type(12'd48, 5'd0, 5'd0, 3'd2));
    for (int i = 1; i <= 8; i++) begin
      r = $random(seed);
      emit(u_type(r[31:12], reg_idx_t'(i), OPCODE_LUI));
      emit(i_type(r[11:0], reg_idx_t'(i), 3'd0, reg_idx_t'(i), OPCODE_OP_IMM));
    end
    for (int k = 0; k < 12; k++) begin
      r     = $random(seed);
      rd    = reg_idx_t'(9 + k % 7);
      f3    = r[14:12];
      // shift immediates keep funct7 legal, bit 30 still picks SRAI
      imm12 = (f3 == 3'd1) ? {7'b0, r[24:20]} :
              (f3 == 3'd5) ? {1'b0, r[30], 5'b0, r[24:20]} : r[31:20];
      case (r[1:0])
        2'd0: emit(r_type({1'b0, r[30] & (f3 == 3'd0 || f3 == 3'd5), 5'b0},
                          {1'b0, r[23:20]}, {1'b0, r[18:15]}, f3, rd, OPCODE_OP));
        2'd1: emit(i_type(imm12, {1'b0, r[18:15]}, f3, rd, OPCODE_OP_IMM));
        2'd2: emit(u_type(r[31:12], rd, OPCODE_LUI));
        default: emit(u_type(r[31:12], rd, OPCODE_AUIPC));
      endcase
      emit(s_type(12'(4 * k), rd, 5'd0, 3'd2));
    end
  endtask

  task automatic branch_program();
    emit(i_type(12'hffb, 5'd0, 3'd0, 5'd1, OPCODE_OP_IMM));
    emit(i_type(12'd7, 5'd0, 3'd0, 5'd2, OPCODE_OP_IMM));
    emit(i_type(12'hffb, 5'd0, 3'd0, 5'd3, OPCODE_OP_IMM));
    for (int c = 0; c < 8; c++) begin
      if (c != 2 && c != 3) begin
        // a taken branch hops over one increment of x4
        emit(b_type(13'd8, 5'd2, 5'd1, 3'(c)));
        emit(i_type(12'd1, 5'd4, 3'd0, 5'd4, OPCODE_OP_IMM));
        emit(b_type(13'd8, 5'd3, 5'd1, 3'(c)));
        emit(i_type(12'd1, 5'd4, 3'd0, 5'd4, OPCODE_OP_IMM));
        // swapped operands make BLTU taken and BGEU not taken
        emit(b_type(13'd8, 5'd1, 5'd2, 3'(c)));
        emit(i_type(12'd1, 5'd4, 3'd0, 5'd4, OPCODE_OP_IMM));
      end
    end
    emit(j_type(21'd8, 5'd5));
    emit(i_type(12'd1, 5'd4, 3'd0, 5'd4, OPCODE_OP_IMM));
    emit(u_type(20'd0, 5'd6, OPCODE_AUIPC));
    // odd offset, so the jump target only works with bit 0 cleared
    emit(i_type(12'd13, 5'd6, 3'd0, 5'd7, OPCODE_JALR));
    emit(i_type(12'd1, 5'd4, 3'd0, 5'd4, OPCODE_OP_IMM));
    emit(s_type(12'd0, 5'd4, 5'd0, 3'd2));
    emit(s_type(12'd4, 5'd5, 5'd0, 3'd2));
    emit(s_type(12'd8, 5'd7, 5'd0, 3'd2));
  endtask

  task automatic load_store_program();
    word_t r;
    r = $random(seed);
    emit(u_type(r[31:12], 5'd1, OPCODE_LUI));
    emit(i_type(r[11:0], 5'd1, 3'd0, 5'd1, OPCODE_OP_IMM));
    emit(i_type(12'd32, 5'd0, 3'd0, 5'd8, OPCODE_OP_IMM));
    emit(s_type(12'd32, 5'd1, 5'd8, 3'd2));
    emit(i_type(12'd32, 5'd8, 3'd2, 5'd2, OPCODE_LOAD));
    emit(s_type(12'd36, 5'd2, 5'd8, 3'd2));
    emit(s_type(12'hffc, 5'd1, 5'd8, 3'd2));
    emit(i_type(12'hffc, 5'd8, 3'd2, 5'd9, OPCODE_LOAD));
    emit(s_type(12'd40, 5'd9, 5'd8, 3'd2));
    // a word nobody wrote still holds its fill value
    emit(i_type(12'd100, 5'd0, 3'd2, 5'd3, OPCODE_LOAD));
    emit(s_type(12'd44, 5'd3, 5'd8, 3'd2));
  endtask

  task automatic x0_noop_program();
    emit(i_type(12'd123, 5'd0, 3'd0, 5'd0, OPCODE_OP_IMM));
    emit(u_type(20'habcde, 5'd0, OPCODE_LUI));
    emit(r_type(7'd0, 5'd0, 5'd0, 3'd0, 5'd0, OPCODE_OP));
    emit(32'h0ff0_000f);
    emit(32'hffff_ffff);
    emit(i_type(12'h7ff, 5'd0, 3'd0, 5'd5, 7'b0001011));
    emit(s_type(12'd0, 5'd0, 5'd0, 3'd2));
    emit(s_type(12'd4, 5'd31, 5'd0, 3'd2));
    emit(s_type(12'd8, 5'd5, 5'd0, 3'd2));
  endtask

  initial begin
    #(TIMEOUT_CYCLES * PERIOD_NS);
    abort_run("watchdog expired before the programs reached their halt loops");
  end

  initial begin
    reset    = 1'b1;
    checking = 1'b0;
    halted   = 1'b0;
    reset_models();
    start_test("alu_random");
    alu_program();
    run_to_halt();
    start_test("branch_jump");
    branch_program();
    run_to_halt();
    start_test("load_store");
    load_store_program();
    run_to_halt();
    start_test("x0_and_noops");
    x0_noop_program();
    run_to_halt();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: rv_simple.f
+incdir+include
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/alu.sv
verilog/immediate_generator.sv
verilog/regfile.sv
verilog/singlecycle_control.sv
verilog/singlecycle_datapath.sv
verilog/rv_core.sv
verification/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the single-cycle RV32I core and its testbench with Verilator, then runs it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f rv_simple.f \
    --top-module rv_core_tb -o sim_rv_core; then
  echo "verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/sim_rv_core 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "RESULT: PASS" <<< "$sim_output"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
